/* hw/sparc_settings.svh */
`ifndef SPARC_SETTINGS_SVH
`define SPARC_SETTINGS_SVH

// Data word width in bits
`define SPARC_XLEN 32

// Integer register count, r0 reads as zero
`define SPARC_NREGS 32

// RAM depth in 32-bit words
`define SPARC_RAM_WORDS 1024

// Byte address of the first instruction after run
`define SPARC_RESET_PC 0

`endif

/* hw/sparc_isa_pkg.sv */
`default_nettype none
`include "sparc_settings.svh"

package sparc_isa_pkg;

	// Register index
	typedef logic [$clog2(`SPARC_NREGS)-1:0] reg_idx_t;

	// Family in bits 31:30, op 01 reused as halt
	typedef enum logic [1:0] {
		OP_BRANCH = 2'b00,
		OP_HALT   = 2'b01,
		OP_ALU    = 2'b10,
		OP_MEM    = 2'b11
	} op_family_t;

	// op3 field, ALU and memory codes overlap
	typedef logic [5:0] op3_t;
	localparam op3_t OP3_ADD   = 6'b000000;
	localparam op3_t OP3_AND   = 6'b000001;
	localparam op3_t OP3_OR    = 6'b000010;
	localparam op3_t OP3_XOR   = 6'b000011;
	localparam op3_t OP3_SUB   = 6'b000100;
	localparam op3_t OP3_ADDCC = 6'b010000;
	localparam op3_t OP3_ANDCC = 6'b010001;
	localparam op3_t OP3_ORCC  = 6'b010010;
	localparam op3_t OP3_XORCC = 6'b010011;
	localparam op3_t OP3_SUBCC = 6'b010100;
	localparam op3_t OP3_LD    = 6'b000000;
	localparam op3_t OP3_LDUB  = 6'b000001;
	localparam op3_t OP3_ST    = 6'b000100;
	localparam op3_t OP3_STB   = 6'b000101;
	localparam op3_t OP3_LDSB  = 6'b001001;
	localparam op3_t OP3_SWAP  = 6'b001111;

	// Bicc conditions, bit 3 inverts the test
	typedef enum logic [3:0] {
		COND_BN, COND_BE, COND_BLE, COND_BL, COND_BLEU, COND_BCS, COND_BNEG, COND_BVS,
		COND_BA, COND_BNE, COND_BG, COND_BGE, COND_BGU, COND_BCC, COND_BPOS, COND_BVC
	} cond_t;

	// Format 3, rs2 sits in simm13[4:0]
	typedef struct packed {
		op_family_t  op;
		reg_idx_t    rd;
		op3_t        op3;
		reg_idx_t    rs1;
		logic        i;
		logic [12:0] simm13;
	} fmt3_t;

	// Format 2 branch
	typedef struct packed {
		op_family_t  op;
		logic        a;
		cond_t       cond;
		logic [2:0]  op2;
		logic [21:0] disp22;
	} fmt2_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
	} alu_op_t;

	typedef struct packed {
		logic n;
		logic z;
		logic v;
		logic c;
	} icc_t;

	typedef struct packed {
		logic [`SPARC_XLEN-1:0] a;
		logic [`SPARC_XLEN-1:0] b;
		alu_op_t                op;
		logic                   set_cc;
	} alu_req_t;

endpackage

`default_nettype wire

/* hw/sparc_bus_pkg.sv */
`default_nettype none
`include "sparc_settings.svh"

package sparc_bus_pkg;

	// Wishbone classic request, master to slave
	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		// Byte address
		logic [31:0]              adr;
		logic [`SPARC_XLEN-1:0]   dat;
		// sel[3] is byte address 0
		logic [`SPARC_XLEN/8-1:0] sel;
	} wb_req_t;

	// Slave response
	typedef struct packed {
		logic                   ack;
		logic [`SPARC_XLEN-1:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

/* hw/register_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sparc_settings.svh"

module register_file
	import sparc_isa_pkg::*;
(
	input  wire                    Clk,
	input  wire                    RESET,
	input  wire reg_idx_t          ra_addr,
	input  wire reg_idx_t          rb_addr,
	output logic [`SPARC_XLEN-1:0] ra_data,
	output logic [`SPARC_XLEN-1:0] rb_data,
	input  wire                    we,
	input  wire reg_idx_t          wr_addr,
	input  wire [`SPARC_XLEN-1:0]  wr_data
);

	logic [`SPARC_XLEN-1:0] regs [`SPARC_NREGS];

	// Writes to r0 never land
	always_ff @(posedge Clk or posedge RESET) begin
		if (RESET) begin
			for (int i = 0; i < `SPARC_NREGS; i++)
				regs[i] <= '0;
		end else if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Async reads, r0 forced to zero
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sparc_settings.svh"

module alu
	import sparc_isa_pkg::*;
(
	input  wire alu_req_t          req,
	output logic [`SPARC_XLEN-1:0] result,
	input  wire icc_t              icc_in,
	output icc_t                   icc_out
);

	localparam int MSB = `SPARC_XLEN - 1;

	// Extra bit holds carry or borrow
	logic [`SPARC_XLEN:0] sum, diff;
	logic v_add, v_sub;

	assign sum  = {1'b0, req.a} + {1'b0, req.b};
	assign diff = {1'b0, req.a} - {1'b0, req.b};
	// Same-sign inputs, result sign flipped
	assign v_add = (req.a[MSB] == req.b[MSB]) && (sum[MSB] != req.a[MSB]);
	// Opposite signs, result differs from a
	assign v_sub = (req.a[MSB] != req.b[MSB]) && (diff[MSB] != req.a[MSB]);

	always_comb begin
		case (req.op)
			ALU_ADD: result = sum[MSB:0];
			ALU_SUB: result = diff[MSB:0];
			ALU_AND: result = req.a & req.b;
			ALU_OR:  result = req.a | req.b;
			ALU_XOR: result = req.a ^ req.b;
			default: result = req.b;
		endcase
	end

	always_comb begin
		icc_out = icc_in;
		if (req.set_cc) begin
			icc_out.n = result[MSB];
			icc_out.z = (result == '0);
			// Logic ops clear v and c
			icc_out.v = 1'b0;
			icc_out.c = 1'b0;
			case (req.op)
				ALU_ADD: begin
					icc_out.v = v_add;
					icc_out.c = sum[`SPARC_XLEN];
				end
				ALU_SUB: begin
					icc_out.v = v_sub;
					icc_out.c = diff[`SPARC_XLEN];
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter
	import sparc_bus_pkg::*;
(
	input  wire          Clk,
	input  wire          RESET,
	input  wire wb_req_t m_req [3],
	output wb_rsp_t      m_rsp [3],
	output wb_req_t      s_req,
	input  wire wb_rsp_t s_rsp
);

	localparam int NM = 3;

	logic [1:0] gnt;
	logic [1:0] pick;
	logic busy;
	logic any_req;

	// Lowest index wins, so scan downward
	always_comb begin
		pick    = '0;
		any_req = 1'b0;
		for (int i = NM - 1; i >= 0; i--) begin
			if (m_req[i].cyc) begin
				pick    = 2'(i);
				any_req = 1'b1;
			end
		end
	end

	// Grant only from idle, hold while cyc stays up
	always_ff @(posedge Clk or posedge RESET) begin
		if (RESET) begin
			busy <= 1'b0;
			gnt  <= '0;
		end else if (!busy) begin
			if (any_req) begin
				busy <= 1'b1;
				gnt  <= pick;
			end
		end else if (!m_req[gnt].cyc) begin
			busy <= 1'b0;
		end
	end

	// Idle bus carries no cycle
	assign s_req = busy ? m_req[gnt] : '0;

	// Ack only to the owner, data broadcast
	always_comb begin
		for (int i = 0; i < NM; i++) begin
			m_rsp[i].ack = busy && (gnt == 2'(i)) && s_rsp.ack;
			m_rsp[i].dat = s_rsp.dat;
		end
	end

endmodule

`default_nettype wire

/* hw/wb_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sparc_settings.svh"

module wb_ram
	import sparc_bus_pkg::*;
(
	input  wire          Clk,
	input  wire          RESET,
	input  wire wb_req_t req,
	output wb_rsp_t      rsp
);

	localparam int AW = $clog2(`SPARC_RAM_WORDS);
	localparam int NB = `SPARC_XLEN / 8;

	logic [`SPARC_XLEN-1:0] mem [`SPARC_RAM_WORDS];
	logic [`SPARC_XLEN-1:0] dat_q;
	logic [AW-1:0] idx;
	logic ack_q;
	logic access;

	// Word index from the byte address
	assign idx = req.adr[AW+1:2];
	// No second ack while the master is still dropping stb
	assign access = req.cyc && req.stb && !ack_q;

	always_ff @(posedge Clk or posedge RESET) begin
		if (RESET)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	// sel[NB-1] is the lowest byte address
	always_ff @(posedge Clk) begin
		if (access) begin
			if (req.we) begin
				for (int b = 0; b < NB; b++) begin
					if (req.sel[b])
						mem[idx][8*b +: 8] <= req.dat[8*b +: 8];
				end
			end
			dat_q <= mem[idx];
		end
	end

	assign rsp = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

/* hw/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sparc_settings.svh"

module control_unit
	import sparc_isa_pkg::*, sparc_bus_pkg::*;
(
	input  wire                          Clk,
	input  wire                          RESET,
	input  wire                          run,
	output logic                         halted,
	output wb_req_t                      fetch_req,
	input  wire wb_rsp_t                 fetch_rsp,
	output wb_req_t                      data_req,
	input  wire wb_rsp_t                 data_rsp,
	output alu_req_t                     alu_req,
	input  wire [`SPARC_XLEN-1:0]        alu_result,
	input  wire icc_t                    alu_icc,
	output reg_idx_t                     ra_addr,
	output reg_idx_t                     rb_addr,
	input  wire [`SPARC_XLEN-1:0]        ra_data,
	input  wire [`SPARC_XLEN-1:0]        rb_data,
	output logic                         rd_we,
	output reg_idx_t                     rd_addr,
	output logic [`SPARC_XLEN-1:0]       rd_data
);

	typedef enum logic [3:0] {
		S_IDLE, S_FETCH, S_DECODE, S_EXECUTE, S_MEM_ADDR,
		S_MEM_ACCESS, S_SWAP_WR, S_WRITEBACK, S_HALTED
	} state_t;

	state_t state;
	logic [`SPARC_XLEN-1:0] pc, ir, mar, mdr;
	icc_t psr_icc;
	fmt3_t f3;
	fmt2_t f2;
	logic [`SPARC_XLEN-1:0] op2, disp, pc_next, lane, load_data;
	logic is_store, is_load, taken, data_active;

	// Bicc test over PSR flags
	function automatic logic cond_holds(cond_t cond, icc_t icc);
		case (cond)
			COND_BN:   cond_holds = 1'b0;
			COND_BE:   cond_holds = icc.z;
			COND_BLE:  cond_holds = icc.z | (icc.n ^ icc.v);
			COND_BL:   cond_holds = icc.n ^ icc.v;
			COND_BLEU: cond_holds = icc.c | icc.z;
			COND_BCS:  cond_holds = icc.c;
			COND_BNEG: cond_holds = icc.n;
			COND_BVS:  cond_holds = icc.v;
			COND_BA:   cond_holds = 1'b1;
			COND_BNE:  cond_holds = ~icc.z;
			COND_BG:   cond_holds = ~(icc.z | (icc.n ^ icc.v));
			COND_BGE:  cond_holds = ~(icc.n ^ icc.v);
			COND_BGU:  cond_holds = ~(icc.c | icc.z);
			COND_BCC:  cond_holds = ~icc.c;
			COND_BPOS: cond_holds = ~icc.n;
			default:   cond_holds = ~icc.v;
		endcase
	endfunction

	// op3 to ALU function, cc forms share the plain one
	function automatic alu_op_t alu_func(op3_t op3);
		case (op3)
			OP3_ADD, OP3_ADDCC: alu_func = ALU_ADD;
			OP3_SUB, OP3_SUBCC: alu_func = ALU_SUB;
			OP3_AND, OP3_ANDCC: alu_func = ALU_AND;
			OP3_OR, OP3_ORCC:   alu_func = ALU_OR;
			OP3_XOR, OP3_XORCC: alu_func = ALU_XOR;
			default:            alu_func = ALU_PASS_B;
		endcase
	endfunction

	// Both formats decoded from the same IR
	assign f3 = fmt3_t'(ir);
	assign f2 = fmt2_t'(ir);
	// Immediate or rs2
	assign op2 = f3.i ? {{(`SPARC_XLEN-13){f3.simm13[12]}}, f3.simm13} : rb_data;
	// Word displacement to bytes
	assign disp = {{(`SPARC_XLEN-24){f2.disp22[21]}}, f2.disp22, 2'b00};
	assign pc_next = pc + 4;
	assign taken = cond_holds(f2.cond, psr_icc);
	assign is_store = (f3.op3 == OP3_ST) || (f3.op3 == OP3_STB);
	assign is_load = f3.op3 inside {OP3_LD, OP3_LDUB, OP3_LDSB};
	assign halted = (state == S_HALTED);

	// Big-endian lane, offset 0 is the top byte
	assign lane = data_rsp.dat >> {~mar[1:0], 3'b000};
	always_comb begin
		case (f3.op3)
			OP3_LDUB: load_data = {{(`SPARC_XLEN-8){1'b0}}, lane[7:0]};
			OP3_LDSB: load_data = {{(`SPARC_XLEN-8){lane[7]}}, lane[7:0]};
			default:  load_data = data_rsp.dat;
		endcase
	end

	// rs1 always on port A
	assign ra_addr = f3.rs1;
	// Store data comes from rd once the address is latched
	assign rb_addr = (state == S_MEM_ACCESS || state == S_SWAP_WR) ? f3.rd : f3.simm13[4:0];
	assign rd_addr = f3.rd;

	always_comb begin
		alu_req.a      = ra_data;
		alu_req.b      = op2;
		alu_req.op     = ALU_ADD;
		alu_req.set_cc = 1'b0;
		case (state)
			S_EXECUTE: begin
				if (f3.op == OP_BRANCH) begin
					// Branch target
					alu_req.a = pc;
					alu_req.b = disp;
				end else begin
					alu_req.op     = alu_func(f3.op3);
					alu_req.set_cc = f3.op3[4];
				end
			end
			// Old memory word of a swap
			S_WRITEBACK: begin
				alu_req.b  = mdr;
				alu_req.op = ALU_PASS_B;
			end
			default: ;
		endcase
	end

	always_comb begin
		rd_we   = 1'b0;
		rd_data = alu_result;
		case (state)
			S_EXECUTE: rd_we = (f3.op == OP_ALU);
			// Load result straight off the bus
			S_MEM_ACCESS: begin
				rd_we   = data_rsp.ack && is_load;
				rd_data = load_data;
			end
			S_WRITEBACK: rd_we = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		fetch_req     = '0;
		fetch_req.cyc = (state == S_FETCH);
		fetch_req.stb = (state == S_FETCH);
		fetch_req.adr = pc;
		fetch_req.sel = '1;
	end

	assign data_active = (state == S_MEM_ACCESS) || (state == S_SWAP_WR);
	always_comb begin
		data_req     = '0;
		data_req.cyc = data_active;
		data_req.stb = data_active;
		data_req.we  = (state == S_SWAP_WR) || (state == S_MEM_ACCESS && is_store);
		data_req.adr = mar;
		data_req.dat = rb_data;
		data_req.sel = '1;
		// stb puts the byte on every lane, sel picks one
		if (f3.op3 == OP3_STB) begin
			data_req.dat = {(`SPARC_XLEN/8){rb_data[7:0]}};
			data_req.sel = 4'b1000 >> mar[1:0];
		end
	end

	always_ff @(posedge Clk or posedge RESET) begin
		if (RESET) begin
			state   <= S_IDLE;
			pc      <= `SPARC_RESET_PC;
			psr_icc <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (run) begin
						pc    <= `SPARC_RESET_PC;
						state <= S_FETCH;
					end
				end
				// Wait out arbitration and RAM
				S_FETCH: begin
					if (fetch_rsp.ack)
						state <= S_DECODE;
				end
				S_DECODE: begin
					case (f3.op)
						OP_BRANCH, OP_ALU: state <= S_EXECUTE;
						OP_MEM:            state <= S_MEM_ADDR;
						default:           state <= S_HALTED;
					endcase
				end
				S_EXECUTE: begin
					if (f3.op == OP_BRANCH && taken)
						pc <= alu_result;
					else
						pc <= pc_next;
					// Only cc forms touch the PSR
					if (alu_req.set_cc)
						psr_icc <= alu_icc;
					state <= S_FETCH;
				end
				S_MEM_ADDR: state <= S_MEM_ACCESS;
				S_MEM_ACCESS: begin
					if (data_rsp.ack) begin
						if (f3.op3 == OP3_SWAP) begin
							state <= S_SWAP_WR;
						end else begin
							pc    <= pc_next;
							state <= S_FETCH;
						end
					end
				end
				S_SWAP_WR: begin
					if (data_rsp.ack)
						state <= S_WRITEBACK;
				end
				S_WRITEBACK: begin
					pc    <= pc_next;
					state <= S_FETCH;
				end
				// Left only through reset
				S_HALTED: state <= S_HALTED;
				default: state <= S_IDLE;
			endcase
		end
	end

	// IR, MAR and MDR
	always_ff @(posedge Clk) begin
		if (state == S_FETCH && fetch_rsp.ack)
			ir <= fetch_rsp.dat;
		if (state == S_MEM_ADDR)
			mar <= alu_result;
		if (state == S_MEM_ACCESS && data_rsp.ack)
			mdr <= data_rsp.dat;
	end

endmodule

`default_nettype wire

/* hw/sparc_core_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sparc_settings.svh"

module sparc_core_top
	import sparc_isa_pkg::*, sparc_bus_pkg::*;
(
	input  wire          Clk,
	input  wire          RESET,
	input  wire          run,
	output logic         halted,
	input  wire wb_req_t host_req,
	output wb_rsp_t      host_rsp
);

	wb_req_t fetch_req, data_req, s_req;
	wb_rsp_t fetch_rsp, data_rsp, s_rsp;
	wb_req_t m_req [3];
	wb_rsp_t m_rsp [3];
	alu_req_t alu_req;
	icc_t alu_icc;
	logic [`SPARC_XLEN-1:0] alu_result, ra_data, rb_data, rd_data;
	reg_idx_t ra_addr, rb_addr, rd_addr;
	logic rd_we;

	// Slot order is priority, host first
	assign m_req[0]  = host_req;
	assign m_req[1]  = data_req;
	assign m_req[2]  = fetch_req;
	assign host_rsp  = m_rsp[0];
	assign data_rsp  = m_rsp[1];
	assign fetch_rsp = m_rsp[2];

	control_unit u_control_unit (
		.Clk        (Clk),
		.RESET      (RESET),
		.run        (run),
		.halted     (halted),
		.fetch_req  (fetch_req),
		.fetch_rsp  (fetch_rsp),
		.data_req   (data_req),
		.data_rsp   (data_rsp),
		.alu_req    (alu_req),
		.alu_result (alu_result),
		.alu_icc    (alu_icc),
		.ra_addr    (ra_addr),
		.rb_addr    (rb_addr),
		.ra_data    (ra_data),
		.rb_data    (rb_data),
		.rd_we      (rd_we),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data)
	);

	register_file u_register_file (
		.Clk     (Clk),
		.RESET   (RESET),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.we      (rd_we),
		.wr_addr (rd_addr),
		.wr_data (rd_data)
	);

	// PSR lives in the sequencer, which latches icc only on cc forms
	alu u_alu (
		.req     (alu_req),
		.result  (alu_result),
		.icc_in  ('0),
		.icc_out (alu_icc)
	);

	wb_arbiter u_wb_arbiter (
		.Clk   (Clk),
		.RESET (RESET),
		.m_req (m_req),
		.m_rsp (m_rsp),
		.s_req (s_req),
		.s_rsp (s_rsp)
	);

	wb_ram u_wb_ram (
		.Clk   (Clk),
		.RESET (RESET),
		.req   (s_req),
		.rsp   (s_rsp)
	);

endmodule

`default_nettype wire

/* verif/core_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sparc_settings.svh"

module core_checker
	import sparc_isa_pkg::*, sparc_bus_pkg::*;
(
	input  wire          Clk,
	input  wire          RESET,
	input  wire          run,
	input  wire          halted,
	input  wire wb_req_t host_req,
	input  wire wb_rsp_t host_rsp,
	output int           errors,
	output int           reads_checked
);

	localparam int MAX_STEPS = 2000;

	// Model copy of the RAM, fed by host writes and the model
	logic [31:0] model_mem [`SPARC_RAM_WORDS];
	logic started;
	logic halted_q;

	initial begin
		for (int k = 0; k < `SPARC_RAM_WORDS; k++)
			model_mem[k] = '0;
		started  = 1'b0;
		halted_q = 1'b0;
	end

	// Low three bits pick the test, bit 3 negates it
	function automatic logic cond_true(input logic [3:0] cond, input logic n, input logic z,
		input logic v, input logic c);
		logic base;
		case (cond[2:0])
			3'd0: base = 1'b0;
			3'd1: base = z;
			3'd2: base = z | (n ^ v);
			3'd3: base = n ^ v;
			3'd4: base = c | z;
			3'd5: base = c;
			3'd6: base = n;
			default: base = v;
		endcase
		return base ^ cond[3];
	endfunction

	// Whole program at ISA level, from reset state
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] pc, pc_next, ir, a, b, res, addr, w, bval;
		logic [4:0] rd;
		logic [5:0] op3;
		logic n, z, v, c, ov, cy, wr, halt_seen;
		longint sa, sb, s;
		int idx, sh, steps, k;
		for (k = 0; k < 32; k++)
			regs[k] = '0;
		pc        = `SPARC_RESET_PC;
		{n, z, v, c} = 4'b0000;
		halt_seen = 1'b0;
		steps     = 0;
		while (!halt_seen && steps < MAX_STEPS) begin
			ir  = model_mem[(pc >> 2) % `SPARC_RAM_WORDS];
			rd  = ir[29:25];
			op3 = ir[24:19];
			a   = regs[ir[18:14]];
			// simm13 sign-extended, else rs2
			b   = ir[13] ? {{19{ir[12]}}, ir[12:0]} : regs[ir[4:0]];
			wr  = 1'b0;
			res = '0;
			pc_next = pc + 4;
			steps++;
			case (ir[31:30])
				2'b01: halt_seen = 1'b1;
				2'b00: begin
					if (cond_true(ir[28:25], n, z, v, c))
						pc_next = pc + {{8{ir[21]}}, ir[21:0], 2'b00};
				end
				2'b10: begin
					sa = $signed(a);
					sb = $signed(b);
					s  = 0;
					cy = 1'b0;
					wr = 1'b1;
					case (op3)
						OP3_ADD, OP3_ADDCC: begin
							res = a + b;
							s   = sa + sb;
							// Wrapped below a means carry out
							cy  = res < a;
						end
						OP3_SUB, OP3_SUBCC: begin
							res = a - b;
							s   = sa - sb;
							cy  = a < b;
						end
						OP3_AND, OP3_ANDCC: res = a & b;
						OP3_OR, OP3_ORCC:   res = a | b;
						OP3_XOR, OP3_XORCC: res = a ^ b;
						default: begin
							$display("Model met unsupported ALU op3 %0h at pc %0h", op3, pc);
							errors++;
						end
					endcase
					// Signed result outside 32 bits
					ov = (s > 64'sh7FFF_FFFF) || (s < -64'sh8000_0000);
					if (op3[4])
						{n, z, v, c} = {res[31], res == 32'h0, ov, cy};
				end
				default: begin
					addr = a + b;
					idx  = (addr >> 2) % `SPARC_RAM_WORDS;
					// Byte 0 is the top lane
					sh   = 8 * (3 - addr[1:0]);
					w    = model_mem[idx];
					bval = (w >> sh) & 32'hFF;
					case (op3)
						OP3_LD: {wr, res} = {1'b1, w};
						OP3_LDUB: {wr, res} = {1'b1, bval};
						OP3_LDSB: {wr, res} = {1'b1, {24{bval[7]}}, bval[7:0]};
						OP3_ST: model_mem[idx] = regs[rd];
						OP3_STB: model_mem[idx] = (w & ~(32'hFF << sh)) | ({24'b0, regs[rd][7:0]} << sh);
						OP3_SWAP: begin
							model_mem[idx] = regs[rd];
							{wr, res} = {1'b1, w};
						end
						default: begin
							$display("Model met unsupported memory op3 %0h at pc %0h", op3, pc);
							errors++;
						end
					endcase
				end
			endcase
			// r0 stays zero
			if (wr && rd != 5'd0)
				regs[rd] = res;
			pc = pc_next;
		end
		if (!halt_seen) begin
			$display("Reference model ran %0d instructions without reaching halt", MAX_STEPS);
			errors++;
		end
	endtask

	// Mid-cycle sampling, all bus fields settled
	always @(negedge Clk) begin : monitor
		int hidx;
		if (RESET) begin
			started  = 1'b0;
			halted_q = 1'b0;
		end else begin
			hidx = (host_req.adr >> 2) % `SPARC_RAM_WORDS;
			if (host_req.cyc && host_req.stb && host_rsp.ack) begin
				if (host_req.we) begin
					for (int b = 0; b < 4; b++)
						if (host_req.sel[b])
							model_mem[hidx][8*b +: 8] = host_req.dat[8*b +: 8];
				end else begin
					reads_checked++;
					if (host_rsp.dat !== model_mem[hidx]) begin
						$display("Fail at %0t ns: host read of %08h returned %08h, model holds %08h",
							$time, host_req.adr, host_rsp.dat, model_mem[hidx]);
						errors++;
					end
				end
			end
			if (run && !started && !halted) begin
				started = 1'b1;
				run_model();
			end
			if (halted && !started) begin
				$display("halted was high at %0t ns before the core was started", $time);
				errors++;
			end
			if (halted_q && !halted) begin
				$display("halted dropped at %0t ns without a reset", $time);
				errors++;
			end
			halted_q = halted;
		end
	end

endmodule

`default_nettype wire

/* verif/tb_sparc_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sparc_core
	import sparc_isa_pkg::*, sparc_bus_pkg::*;
();

	localparam int CLK_PERIOD      = 8;
	localparam int NUM_PROGS       = 8;
	localparam int CYCLES_PER_PROG = 4000;
	localparam int RANDOM_INSNS    = 40;
	localparam int WATCHDOG_NS     = (NUM_PROGS + 1) * CYCLES_PER_PROG * CLK_PERIOD;
	localparam logic [31:0] PROG_BASE = 32'h000;
	localparam logic [31:0] DATA_BASE = 32'h200;
	localparam logic [31:0] DUMP_BASE = 32'h300;

	logic Clk;
	logic RESET;
	logic run;
	logic halted;
	wb_req_t host_req;
	wb_rsp_t host_rsp;
	logic [15:0] lfsr;
	logic [31:0] prog [$];
	logic [31:0] rdata;
	int tb_errors;
	int chk_errors;
	int reads_checked;

	sparc_core_top u_sparc_core_top (
		.Clk      (Clk),
		.RESET    (RESET),
		.run      (run),
		.halted   (halted),
		.host_req (host_req),
		.host_rsp (host_rsp)
	);

	// Reference model and host read-back comparison
	core_checker u_core_checker (
		.Clk           (Clk),
		.RESET         (RESET),
		.run           (run),
		.halted        (halted),
		.host_req      (host_req),
		.host_rsp      (host_rsp),
		.errors        (chk_errors),
		.reads_checked (reads_checked)
	);

	initial begin
		Clk = 1'b0;
		forever #(CLK_PERIOD / 2) Clk = ~Clk;
	end

	// Taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic logic [31:0] enc_fmt3(input logic [1:0] op, input logic [4:0] rd,
		input logic [5:0] op3, input logic [4:0] rs1, input logic i, input logic [12:0] low);
		return {op, rd, op3, rs1, i, low};
	endfunction

	// Bicc with annul clear and op2 of 010
	function automatic logic [31:0] enc_branch(input logic [3:0] cond, input logic [21:0] disp);
		return {2'b00, 1'b0, cond, 3'b010, disp};
	endfunction

	function automatic op3_t pick_alu_op3(input logic [3:0] k);
		case (k % 10)
			0: return OP3_ADD;
			1: return OP3_ADDCC;
			2: return OP3_SUB;
			3: return OP3_SUBCC;
			4: return OP3_AND;
			5: return OP3_ANDCC;
			6: return OP3_OR;
			7: return OP3_ORCC;
			8: return OP3_XOR;
			default: return OP3_XORCC;
		endcase
	endfunction

	// Every call starts and ends 1 ns after a rising edge
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge Clk);
			#1;
		end
	endtask

	task automatic apply_reset();
		RESET = 1'b1;
		repeat (4) @(posedge Clk);
		#1;
		RESET = 1'b0;
	endtask

	// Classic cycle with cyc dropped the cycle after ack and one idle cycle after
	task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		host_req.cyc = 1'b1;
		host_req.stb = 1'b1;
		host_req.we  = we;
		host_req.adr = adr;
		host_req.dat = wdat;
		host_req.sel = 4'hF;
		do
			idle_cycles(1);
		while (!host_rsp.ack);
		rdat = host_rsp.dat;
		idle_cycles(1);
		host_req = '0;
		idle_cycles(1);
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
		bus_cycle(1'b0, adr, 32'h0, dat);
	endtask

	task automatic pulse_run();
		run = 1'b1;
		idle_cycles(1);
		run = 1'b0;
	endtask

	// Constant loads then random body then register dump and halt
	task automatic build_program();
		logic [2:0] kind;
		logic [4:0] rd, rs1;
		logic [5:0] off;
		logic [1:0] lsel;
		op3_t op3;
		prog.delete();
		for (int r = 1; r <= 8; r++)
			prog.push_back(enc_fmt3(2'b11, 5'(r), OP3_LD, 5'd0, 1'b1,
				13'(DATA_BASE + 4 * (r - 1))));
		for (int k = 0; k < RANDOM_INSNS; k++) begin
			kind = rand_bits(3);
			rd   = rand_bits(4);
			rs1  = rand_bits(4);
			// Byte offset inside the 64-byte data area
			off  = rand_bits(6);
			case (kind)
				3'd4: begin
					lsel = rand_bits(2);
					op3  = (lsel == 2'd1) ? OP3_LDUB : (lsel == 2'd2) ? OP3_LDSB : OP3_LD;
					if (op3 == OP3_LD)
						off[1:0] = 2'b00;
					prog.push_back(enc_fmt3(2'b11, rd, op3, 5'd0, 1'b1, 13'(DATA_BASE + off)));
				end
				3'd5: begin
					op3 = rand_bits(1) ? OP3_STB : OP3_ST;
					if (op3 == OP3_ST)
						off[1:0] = 2'b00;
					prog.push_back(enc_fmt3(2'b11, rd, op3, 5'd0, 1'b1, 13'(DATA_BASE + off)));
				end
				3'd6: begin
					off[1:0] = 2'b00;
					prog.push_back(enc_fmt3(2'b11, rd, OP3_SWAP, 5'd0, 1'b1,
						13'(DATA_BASE + off)));
				end
				// Forward skip of one to four instructions
				3'd7: prog.push_back(enc_branch(4'(rand_bits(4)), 22'(2 + rand_bits(2))));
				default: begin
					op3 = pick_alu_op3(4'(rand_bits(4)));
					if (rand_bits(1))
						prog.push_back(enc_fmt3(2'b10, rd, op3, rs1, 1'b1, 13'(rand_bits(13))));
					else
						prog.push_back(enc_fmt3(2'b10, rd, op3, rs1, 1'b0, {8'b0, 5'(rand_bits(4))}));
				end
			endcase
		end
		for (int r = 1; r <= 15; r++)
			prog.push_back(enc_fmt3(2'b11, 5'(r), OP3_ST, 5'd0, 1'b1,
				13'(DUMP_BASE + 4 * (r - 1))));
		prog.push_back({2'b01, 30'd0});
	endtask

	task automatic load_memory();
		for (int k = 0; k < prog.size(); k++)
			bus_write(PROG_BASE + 4 * k, prog[k]);
		for (int k = 0; k < 16; k++)
			bus_write(DATA_BASE + 4 * k, rand_bits(32));
		// Address-tagged fill shows dump stores that never happened
		for (int k = 0; k < 15; k++)
			bus_write(DUMP_BASE + 4 * k, 32'hD0D0_0000 | (DUMP_BASE + 4 * k));
	endtask

	task automatic read_back();
		for (int k = 0; k < 15; k++)
			bus_read(DUMP_BASE + 4 * k, rdata);
		for (int k = 0; k < 16; k++)
			bus_read(DATA_BASE + 4 * k, rdata);
	endtask

	task automatic wait_for_halt(output logic ok);
		int n;
		n = 0;
		while (!halted && n < CYCLES_PER_PROG) begin
			idle_cycles(1);
			n++;
		end
		ok = halted;
	endtask

	// Global limit for a stuck bus cycle
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
		$display("Errors: checker %0d, testbench %0d, reads compared %0d",
			chk_errors, tb_errors, reads_checked);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		logic ok;
		logic [31:0] mid_adr;
		host_req  = '0;
		run       = 1'b0;
		RESET     = 1'b1;
		lfsr      = 16'd62;
		tb_errors = 0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			apply_reset();
			build_program();
			load_memory();
			pulse_run();
			// Host read of a program word while the core runs
			idle_cycles(rand_bits(4));
			mid_adr = PROG_BASE + 4 * (rand_bits(6) % prog.size());
			bus_read(mid_adr, rdata);
			wait_for_halt(ok);
			if (!ok) begin
				$display("halted did not rise within %0d cycles on program %0d",
					CYCLES_PER_PROG, p);
				tb_errors++;
				break;
			end
			idle_cycles(4);
			if (!halted) begin
				$display("halted did not stay high after program %0d", p);
				tb_errors++;
			end
			read_back();
		end
		idle_cycles(2);
		$display("Errors: checker %0d, testbench %0d, reads compared %0d",
			chk_errors, tb_errors, reads_checked);
		if (chk_errors == 0 && tb_errors == 0 && reads_checked > 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hw
hw/sparc_isa_pkg.sv
hw/sparc_bus_pkg.sv
hw/register_file.sv
hw/alu.sv
hw/wb_arbiter.sv
hw/wb_ram.sv
hw/control_unit.sv
hw/sparc_core_top.sv
verif/core_checker.sv
verif/tb_sparc_core.sv

/* Bender.yml */
package:
  name: sparc_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/sparc_isa_pkg.sv
      - hw/sparc_bus_pkg.sv
      - hw/register_file.sv
      - hw/alu.sv
      - hw/wb_arbiter.sv
      - hw/wb_ram.sv
      - hw/control_unit.sv
      - hw/sparc_core_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/core_checker.sv
      - verif/tb_sparc_core.sv
